//--- all.f
+incdir+testbench
verilog/core_pkg.sv
verilog/hazard_if.sv
verilog/hazard_unit.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/core.sv
testbench/tb_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_core -f all.f -o tb_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qxF '>>> PASS'; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- testbench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// RV32I encoders, fields cut from plain ints
function automatic xlen_t r_type(int f7, int f3, int rd, int rs1, int rs2);
	return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg};
endfunction

function automatic xlen_t i_type(logic [6:0] op, int f3, int rd, int rs1, int imm);
	return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic xlen_t s_type(int rs2, int rs1, int imm);
	return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};   // SW only
endfunction

// Offset is in bytes from the branch itself
function automatic xlen_t b_type(int f3, int rs1, int rs2, int off);
	return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], op_branch};
endfunction

function automatic xlen_t u_type(int rd, xlen_t val);
	return {val[31:12], rd[4:0], op_lui};
endfunction

function automatic xlen_t j_type(int rd, int off);
	return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
endfunction

task automatic emit(xlen_t w);
	prog.push_back(w);
endtask

// LUI then ADDI; upper half rounded since the low 12 bits get sign extended
task automatic load_const(int rd, xlen_t v);
	xlen_t upper;
	upper = v + 32'h800;
	emit(u_type(rd, upper));
	emit(i_type(op_imm, 0, rd, rd, int'(v)));
endtask

task automatic end_program();
	load_const(31, done_marker);
	emit(s_type(31, 0, -4));      // -4 wraps onto the last data word
	emit(b_type(0, 0, 0, 0));     // beq x0,x0,0 spins here
	emit(nop_inst);
	emit(nop_inst);               // Fetched behind the spin, always flushed
endtask

// Dependent chain, results of x3..x11 land in words 0..8
task automatic alu_chain_image(xlen_t a, xlen_t b, int imm, xlen_t up);
	prog.delete();
	load_const(1, a);
	load_const(2, b);
	emit(r_type(0, 0, 3, 1, 2));      // add x3,x1,x2
	emit(r_type(32, 0, 4, 3, 1));     // sub x4,x3,x1
	emit(r_type(0, 7, 5, 4, 3));      // and x5,x4,x3  x3 from MEM
	emit(r_type(0, 6, 6, 5, 1));      // or  x6,x5,x1
	emit(r_type(0, 4, 7, 6, 4));      // xor x7,x6,x4  x4 from WB
	emit(r_type(0, 2, 8, 7, 5));      // slt x8,x7,x5
	emit(i_type(op_imm, 0, 9, 8, imm));
	emit(u_type(10, up));
	emit(r_type(0, 0, 11, 10, 9));    // EXE and MEM at once
	for (int r = 3; r <= 11; r++)
		emit(s_type(r, 0, (r - 3) * 4));
	end_program();
endtask

// Each load is used by the very next instruction
task automatic load_use_image();
	prog.delete();
	emit(i_type(op_load, 2, 1, 0, 64));   // lw x1,64(x0)
	emit(r_type(0, 0, 2, 1, 1));          // add x2,x1,x1
	emit(i_type(op_load, 2, 3, 0, 68));
	emit(r_type(32, 0, 4, 3, 2));         // sub x4,x3,x2
	emit(i_type(op_load, 2, 5, 0, 64));
	emit(i_type(op_imm, 0, 6, 5, -1));
	emit(s_type(2, 0, 0));
	emit(s_type(4, 0, 4));
	emit(s_type(6, 0, 8));
	emit(s_type(1, 0, 12));
	end_program();
endtask

task automatic branch_image(xlen_t a, xlen_t tag);
	prog.delete();
	load_const(1, a);
	load_const(2, a);
	load_const(3, a + 32'd1);
	load_const(4, tag);
	emit(b_type(0, 1, 2, 12));     // beq taken over two stores
	emit(s_type(4, 0, 0));
	emit(s_type(4, 0, 4));
	emit(b_type(1, 1, 3, 12));     // bne taken
	emit(s_type(4, 0, 8));
	emit(s_type(4, 0, 12));
	emit(b_type(0, 1, 3, 8));      // Not taken, store below runs
	emit(s_type(4, 0, 16));
	emit(b_type(1, 1, 2, 8));
	emit(s_type(4, 0, 20));
	end_program();
endtask

task automatic jal_image(xlen_t tag, output int link);
	prog.delete();
	load_const(5, tag);
	link = (prog.size() + 1) * 4;  // Byte address behind the JAL
	emit(j_type(1, 8));            // jal x1,+8
	emit(s_type(5, 0, 0));         // Skipped
	emit(s_type(1, 0, 4));         // Link forwarded from MEM
	emit(j_type(0, 8));            // Link to x0 is dropped
	emit(s_type(5, 0, 8));
	emit(s_type(5, 0, 12));
	end_program();
endtask

task automatic zero_reg_image(xlen_t v);
	prog.delete();
	emit(i_type(op_imm, 0, 0, 0, 123));   // addi x0,x0,123
	emit(u_type(0, v));                   // lui x0
	emit(i_type(op_imm, 0, 1, 0, 5));     // x0 read right behind both writes
	emit(s_type(0, 0, 0));
	emit(s_type(1, 0, 4));
	end_program();
endtask

`endif

//--- testbench/tb_core.sv
module tb_core import core_pkg::*; ();

	localparam xlen_t      done_marker  = 32'hC0DE_D0E5;
	localparam dmem_addr_t done_word    = '1;      // Last data word
	localparam int         done_timeout = 2000;    // Cycles

	logic       clk;
	logic       rst_n;
	logic       imem_write;
	pc_t        imem_addr;
	xlen_t      imem_data;
	logic       con_write;
	dmem_addr_t con_addr;
	xlen_t      con_in;
	xlen_t      con_out;

	xlen_t prog [$];               // Program image under construction
	int    tests = 0;
	int    checks = 0;
	int    errors = 0;
	int    test_errors = 0;

	`include "tb_programs.svh"

	core core_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_write (imem_write),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.con_write  (con_write),
		.con_addr   (con_addr),
		.con_in     (con_in),
		.con_out    (con_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_word(string what, xlen_t got, xlen_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic write_word(dmem_addr_t a, xlen_t d);
		@(posedge clk);
		con_write <= 1'b1;
		con_addr  <= a;
		con_in    <= d;
		@(posedge clk);             // Written on this edge
		con_write <= 1'b0;
	endtask

	// con_out follows the address one cycle later, sampled mid-cycle
	task automatic read_word(dmem_addr_t a, output xlen_t v);
		@(posedge clk);
		con_addr <= a;
		@(posedge clk);
		@(negedge clk);
		v = con_out;
	endtask

	task automatic fill_imem();
		foreach (prog[i]) begin
			@(posedge clk);
			imem_write <= 1'b1;
			imem_addr  <= pc_t'(i * 4);
			imem_data  <= prog[i];
		end
		@(posedge clk);
		imem_write <= 1'b0;
	endtask

	// Leaves the core in reset so data words can still be preloaded
	task automatic reset_and_load();
		test_errors = 0;
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (3) @(posedge clk);
		fill_imem();
		write_word(done_word, '0);    // Marker of the previous program
	endtask

	task automatic wait_done(output bit ok);
		ok = 1'b0;
		@(posedge clk);
		con_addr <= done_word;
		for (int n = 0; n < done_timeout && !ok; n++) begin
			@(negedge clk);
			if (con_out === done_marker)
				ok = 1'b1;
		end
		if (!ok) begin
			errors++;
			test_errors++;
			$display("Timeout: done marker not seen within %0d cycles", done_timeout);
		end
	endtask

	task automatic release_and_wait(output bit ok);
		@(posedge clk);
		rst_n <= 1'b1;
		wait_done(ok);
	endtask

	task automatic report_test(string name);
		tests++;
		if (test_errors == 0)
			$display("test %s: passed", name);
		else
			$display("test %s: %0d errors", name, test_errors);
	endtask

	task automatic alu_chain_test();
		xlen_t a, b, up, got;
		xlen_t exp [9];
		int    imm;
		bit    ok;
		a   = $urandom;
		b   = $urandom;
		up  = $urandom;
		imm = int'($urandom % 32'd4096) - 2048;
		alu_chain_image(a, b, imm, up);
		exp[0] = a + b;
		exp[1] = exp[0] - a;
		exp[2] = exp[1] & exp[0];
		exp[3] = exp[2] | a;
		exp[4] = exp[3] ^ exp[1];
		exp[5] = ($signed(exp[4]) < $signed(exp[2])) ? 32'd1 : 32'd0;
		exp[6] = exp[5] + xlen_t'(imm);
		exp[7] = {up[31:12], 12'h000};    // LUI
		exp[8] = exp[7] + exp[6];
		reset_and_load();
		release_and_wait(ok);
		if (ok) begin
			for (int i = 0; i < 9; i++) begin
				read_word(dmem_addr_t'(i), got);
				check_word($sformatf("alu result x%0d", i + 3), got, exp[i]);
			end
		end
		report_test("alu_chain");
	endtask

	task automatic load_use_test();
		xlen_t c, d, got;
		xlen_t exp [4];
		bit    ok;
		c = $urandom;
		d = $urandom;
		load_use_image();
		exp[0] = c + c;
		exp[1] = d - exp[0];
		exp[2] = c - 32'd1;
		exp[3] = c;
		reset_and_load();
		write_word(10'd16, c);        // Byte address 64
		write_word(10'd17, d);
		release_and_wait(ok);
		if (ok) begin
			for (int i = 0; i < 4; i++) begin
				read_word(dmem_addr_t'(i), got);
				check_word($sformatf("load-use word %0d", i), got, exp[i]);
			end
		end
		report_test("load_use");
	endtask

	task automatic branch_test();
		xlen_t a, tag, got;
		xlen_t sent [6];
		bit    ok;
		a   = $urandom;
		tag = $urandom;
		branch_image(a, tag);
		reset_and_load();
		for (int i = 0; i < 6; i++) begin
			sent[i] = $urandom;
			write_word(dmem_addr_t'(i), sent[i]);
		end
		release_and_wait(ok);
		if (ok) begin
			for (int i = 0; i < 6; i++) begin
				read_word(dmem_addr_t'(i), got);
				check_word($sformatf("branch word %0d", i), got, (i < 4) ? sent[i] : tag);
			end
		end
		report_test("branch");
	endtask

	task automatic jal_test();
		xlen_t tag, got;
		xlen_t sent [4];
		xlen_t exp [4];
		int    link;
		bit    ok;
		tag = $urandom;
		jal_image(tag, link);
		reset_and_load();
		for (int i = 0; i < 4; i++) begin
			sent[i] = $urandom;
			write_word(dmem_addr_t'(i), sent[i]);
		end
		exp[0] = sent[0];             // Store after JAL never runs
		exp[1] = xlen_t'(link);
		exp[2] = sent[2];
		exp[3] = tag;
		release_and_wait(ok);
		if (ok) begin
			for (int i = 0; i < 4; i++) begin
				read_word(dmem_addr_t'(i), got);
				check_word($sformatf("jal word %0d", i), got, exp[i]);
			end
		end
		report_test("jal");
	endtask

	task automatic zero_and_port_test();
		xlen_t      got, d0, d1;
		dmem_addr_t a;
		bit         ok;
		zero_reg_image($urandom);
		reset_and_load();
		write_word(10'd0, 32'hFFFF_FFFF);
		write_word(10'd1, '0);
		release_and_wait(ok);
		if (ok) begin
			read_word(10'd0, got);
			check_word("store of x0", got, '0);
			read_word(10'd1, got);
			check_word("addi from x0", got, 32'd5);
			// Controller round trip away from program data
			a  = dmem_addr_t'(100 + $urandom % 800);
			d0 = $urandom;
			d1 = $urandom;
			write_word(a, d0);
			write_word(dmem_addr_t'(a + 1), d1);
			read_word(dmem_addr_t'(a + 1), got);
			check_word("port word a+1", got, d1);
			read_word(a, got);
			check_word("port word a", got, d0);
		end
		report_test("zero_and_port");
	endtask

	initial begin
		rst_n      <= 1'b0;
		imem_write <= 1'b0;
		imem_addr  <= '0;
		imem_data  <= '0;
		con_write  <= 1'b0;
		con_addr   <= '0;
		con_in     <= '0;
		void'($urandom(32'h1483_d948));
		alu_chain_test();
		load_use_test();
		branch_test();
		jal_test();
		zero_and_port_test();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- verilog/core.sv
module core import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       imem_write,     // Program load, honoured in reset only
	input  pc_t        imem_addr,
	input  xlen_t      imem_data,
	input  logic       con_write,      // Protocol controller port
	input  dmem_addr_t con_addr,
	input  xlen_t      con_in,
	output xlen_t      con_out
);

	if_id_t    if_id;
	id_exe_t   id_exe;
	exe_mem_t  exe_mem;
	rf_write_t wb;
	reg_addr_t id_rs1, id_rs2;
	logic      jal_taken, redirect_taken;
	pc_t       jal_pc, redirect_pc;
	xlen_t     exe_fwd_data, mem_fwd_data;

	hazard_if hz_i ();

	hazard_unit hazard_unit_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.id_rs1         (id_rs1),
		.id_rs2         (id_rs2),
		.id_exe         (id_exe),
		.exe_mem        (exe_mem),
		.wb             (wb),
		.redirect_taken (redirect_taken),
		.jal_taken      (jal_taken),
		.hz             (hz_i.hazard)
	);

	fetch_stage fetch_stage_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.imem_write     (imem_write),
		.imem_addr      (imem_addr),
		.imem_data      (imem_data),
		.redirect_taken (redirect_taken),
		.redirect_pc    (redirect_pc),
		.jal_taken      (jal_taken),
		.jal_pc         (jal_pc),
		.hz             (hz_i.fetch),
		.if_id          (if_id)
	);

	decode_stage decode_stage_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.if_id        (if_id),
		.wb           (wb),
		.exe_fwd_data (exe_fwd_data),
		.mem_fwd_data (mem_fwd_data),
		.hz           (hz_i.decode),
		.stall        (hz_i.stall_decode),  // Load-use bubble into ID/EXE
		.id_rs1       (id_rs1),
		.id_rs2       (id_rs2),
		.jal_taken    (jal_taken),
		.jal_pc       (jal_pc),
		.id_exe       (id_exe)
	);

	execute_stage execute_stage_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.id_exe         (id_exe),
		.exe_fwd_data   (exe_fwd_data),
		.redirect_taken (redirect_taken),
		.redirect_pc    (redirect_pc),
		.exe_mem        (exe_mem)
	);

	memory_stage memory_stage_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.exe_mem      (exe_mem),
		.con_write    (con_write),
		.con_addr     (con_addr),
		.con_in       (con_in),
		.con_out      (con_out),
		.mem_fwd_data (mem_fwd_data),
		.wb           (wb)
	);

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

	localparam int xlen       = 32;                 // Data word width
	localparam int pc_width   = 12;                 // Byte address into instruction memory
	localparam int imem_words = 1024;
	localparam int dmem_words = 1024;

	typedef logic [xlen-1:0]               xlen_t;
	typedef logic [pc_width-1:0]           pc_t;
	typedef logic [$clog2(dmem_words)-1:0] dmem_addr_t;   // Word index, not byte
	typedef logic [4:0]                    reg_addr_t;

	// Major opcodes that survive decode
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	localparam xlen_t nop_inst = 32'h0000_0013;     // ADDI x0,x0,0

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
	} alu_op_t;

	typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4} wb_sel_t;

	typedef enum logic [1:0] {fwd_none, fwd_exe, fwd_mem, fwd_wb} fwd_sel_t;

	typedef struct packed {
		pc_t   pc;
		pc_t   pc4;
		xlen_t inst;
		logic  valid;
	} if_id_t;

	typedef struct packed {
		pc_t       pc4;
		xlen_t     op_a;
		xlen_t     op_b;          // Immediate already muxed in
		xlen_t     store_data;
		reg_addr_t rd;
		logic      wr_en;
		logic      is_load;
		logic      is_store;
		logic      is_branch;
		logic      branch_ne;     // BNE when set, BEQ otherwise
		alu_op_t   alu_op;
		wb_sel_t   wb_sel;
		pc_t       branch_target;
		logic      valid;
	} id_exe_t;

	typedef struct packed {
		xlen_t     alu_result;
		xlen_t     store_data;
		pc_t       pc4;
		reg_addr_t rd;
		logic      wr_en;
		logic      is_load;
		logic      is_store;
		wb_sel_t   wb_sel;
	} exe_mem_t;

	typedef struct packed {
		xlen_t     alu_result;
		xlen_t     load_data;
		pc_t       pc4;
		reg_addr_t rd;
		logic      wr_en;
		wb_sel_t   wb_sel;
	} mem_wb_t;

	typedef struct packed {
		logic      en;
		reg_addr_t rd;
		xlen_t     data;
	} rf_write_t;

	// Result select shared by the EXE forward, the MEM forward and writeback
	function automatic xlen_t wb_mux(wb_sel_t sel, xlen_t alu, xlen_t load, pc_t pc4);
		case (sel)
			wb_load: return load;
			wb_pc4:  return xlen_t'(pc4);     // Link value, zero extended
			default: return alu;
		endcase
	endfunction

endpackage

//--- verilog/decode_stage.sv
module decode_stage import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  if_id_t    if_id,
	input  rf_write_t wb,
	input  xlen_t     exe_fwd_data,
	input  xlen_t     mem_fwd_data,
	hazard_if.decode  hz,
	input  logic      stall,
	output reg_addr_t id_rs1,
	output reg_addr_t id_rs2,
	output logic      jal_taken,
	output pc_t       jal_pc,
	output id_exe_t   id_exe
);

	xlen_t     rf [32];
	xlen_t     inst;
	reg_addr_t rd;
	xlen_t     imm_i, imm_s, imm_b, imm_u, imm_j;
	xlen_t     imm;
	xlen_t     rs1_val, rs2_val;
	alu_op_t   alu_op;
	wb_sel_t   wb_sel;
	logic      use_rs1, use_rs2, use_imm;
	logic      wr;
	logic      is_load, is_store, is_branch, is_jal;
	id_exe_t   id_next;

	assign inst = if_id.inst;
	assign rd   = inst[11:7];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		alu_op    = alu_add;
		wb_sel    = wb_alu;
		imm       = imm_i;
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		use_imm   = 1'b0;
		wr        = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		if (if_id.valid) begin
			case (inst[6:0])
				op_reg: begin
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
					wr      = 1'b1;
					case ({inst[31:25], inst[14:12]})
						10'b0000000_000: alu_op = alu_add;
						10'b0100000_000: alu_op = alu_sub;
						10'b0000000_111: alu_op = alu_and;
						10'b0000000_110: alu_op = alu_or;
						10'b0000000_100: alu_op = alu_xor;
						10'b0000000_010: alu_op = alu_slt;
						default: begin          // Unsupported R-type, no-op
							use_rs1 = 1'b0;
							use_rs2 = 1'b0;
							wr      = 1'b0;
						end
					endcase
				end
				op_imm: if (inst[14:12] == 3'b000) begin   // ADDI only
					use_rs1 = 1'b1;
					use_imm = 1'b1;
					wr      = 1'b1;
				end
				op_lui: begin
					imm     = imm_u;
					use_imm = 1'b1;
					alu_op  = alu_pass_b;
					wr      = 1'b1;
				end
				op_load: if (inst[14:12] == 3'b010) begin  // LW
					use_rs1 = 1'b1;
					use_imm = 1'b1;
					wb_sel  = wb_load;
					is_load = 1'b1;
					wr      = 1'b1;
				end
				op_store: if (inst[14:12] == 3'b010) begin // SW
					imm      = imm_s;
					use_rs1  = 1'b1;
					use_rs2  = 1'b1;
					use_imm  = 1'b1;
					is_store = 1'b1;
				end
				op_branch: if (inst[14:13] == 2'b00) begin // BEQ, BNE
					imm       = imm_b;
					use_rs1   = 1'b1;
					use_rs2   = 1'b1;
					is_branch = 1'b1;
				end
				op_jal: begin
					imm    = imm_j;
					wb_sel = wb_pc4;
					is_jal = 1'b1;
					wr     = 1'b1;
				end
				default: ;                    // Everything else retires as a no-op
			endcase
		end
	end

	// Unused source fields read as x0 so they never trip forwarding or a stall
	assign id_rs1 = use_rs1 ? inst[19:15] : '0;
	assign id_rs2 = use_rs2 ? inst[24:20] : '0;

	always_ff @(posedge clk) begin
		if (wb.en)
			rf[wb.rd] <= wb.data;
	end

	// WB forward gives write-before-read on the same edge
	function automatic xlen_t operand(fwd_sel_t sel, reg_addr_t rs);
		case (sel)
			fwd_exe: return exe_fwd_data;
			fwd_mem: return mem_fwd_data;
			fwd_wb:  return wb.data;
			default: return (rs == '0) ? '0 : rf[rs];
		endcase
	endfunction

	assign rs1_val = operand(hz.fwd_a, id_rs1);
	assign rs2_val = operand(hz.fwd_b, id_rs2);

	assign jal_taken = is_jal;
	assign jal_pc    = if_id.pc + imm[pc_width-1:0];

	always_comb begin
		id_next = '{
			pc4:           if_id.pc4,
			op_a:          rs1_val,
			op_b:          use_imm ? imm : rs2_val,
			store_data:    rs2_val,
			rd:            rd,
			wr_en:         wr && rd != '0,     // Writes to x0 dropped here
			is_load:       is_load,
			is_store:      is_store,
			is_branch:     is_branch,
			branch_ne:     inst[12],
			alu_op:        alu_op,
			wb_sel:        wb_sel,
			branch_target: if_id.pc + imm[pc_width-1:0],
			valid:         if_id.valid
		};
	end

	always_ff @(posedge clk) begin
		if (!rst_n || hz.flush_exe || stall) begin   // Bubble
			id_exe.valid     <= 1'b0;
			id_exe.wr_en     <= 1'b0;
			id_exe.is_load   <= 1'b0;
			id_exe.is_store  <= 1'b0;
			id_exe.is_branch <= 1'b0;
		end else begin
			id_exe <= id_next;
		end
	end

	// Enable travels three stages before it reaches the write port
	a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wb.en |-> wb.rd != '0);

endmodule

//--- verilog/execute_stage.sv
module execute_stage import core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  id_exe_t  id_exe,
	output xlen_t    exe_fwd_data,
	output logic     redirect_taken,
	output pc_t      redirect_pc,
	output exe_mem_t exe_mem
);

	xlen_t alu_y;
	logic  equal;

	always_comb begin
		case (id_exe.alu_op)
			alu_add:    alu_y = id_exe.op_a + id_exe.op_b;
			alu_sub:    alu_y = id_exe.op_a - id_exe.op_b;
			alu_and:    alu_y = id_exe.op_a & id_exe.op_b;
			alu_or:     alu_y = id_exe.op_a | id_exe.op_b;
			alu_xor:    alu_y = id_exe.op_a ^ id_exe.op_b;
			alu_slt:    alu_y = xlen_t'($signed(id_exe.op_a) < $signed(id_exe.op_b));
			alu_pass_b: alu_y = id_exe.op_b;    // LUI
			default:    alu_y = '0;
		endcase
	end

	// A load here stalls decode instead, so no load word is needed
	assign exe_fwd_data = wb_mux(id_exe.wb_sel, alu_y, '0, id_exe.pc4);

	// Branch operands are rs1 and rs2, op_b holds no immediate for branches
	assign equal          = id_exe.op_a == id_exe.op_b;
	assign redirect_taken = id_exe.valid && id_exe.is_branch && (equal ^ id_exe.branch_ne);
	assign redirect_pc    = id_exe.branch_target;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exe_mem.wr_en    <= 1'b0;
			exe_mem.is_load  <= 1'b0;
			exe_mem.is_store <= 1'b0;
		end else begin
			exe_mem <= '{
				alu_result: alu_y,        // Also the byte address for LW/SW
				store_data: id_exe.store_data,
				pc4:        id_exe.pc4,
				rd:         id_exe.rd,
				wr_en:      id_exe.wr_en,
				is_load:    id_exe.is_load,
				is_store:   id_exe.is_store,
				wb_sel:     id_exe.wb_sel
			};
		end
	end

endmodule

//--- verilog/fetch_stage.sv
module fetch_stage import core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     imem_write,
	input  pc_t      imem_addr,
	input  xlen_t    imem_data,
	input  logic     redirect_taken,
	input  pc_t      redirect_pc,
	input  logic     jal_taken,
	input  pc_t      jal_pc,
	hazard_if.fetch  hz,
	output if_id_t   if_id
);

	xlen_t imem [imem_words];
	pc_t   pc;
	pc_t   pc4;
	pc_t   pc_next;
	xlen_t inst;

	// Program load only while the core sits in reset
	always_ff @(posedge clk) begin
		if (!rst_n && imem_write)
			imem[imem_addr[pc_width-1:2]] <= imem_data;
	end

	assign inst = imem[pc[pc_width-1:2]];   // Async read
	assign pc4  = pc + pc_t'(4);

	// Branch from EXE beats JAL from ID, not-taken is the default guess
	always_comb begin
		if (redirect_taken)
			pc_next = redirect_pc;
		else if (jal_taken)
			pc_next = jal_pc;
		else if (hz.stall_fetch)
			pc_next = pc;               // Load-use hold
		else
			pc_next = pc4;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= '0;
		else
			pc <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (!rst_n || hz.flush_decode) begin
			if_id.valid <= 1'b0;
			if_id.inst  <= nop_inst;    // Decodes to nothing
		end else if (!hz.stall_decode) begin
			if_id <= '{pc: pc, pc4: pc4, inst: inst, valid: 1'b1};
		end
	end

	// Targets come from decode and execute, all of them word multiples
	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		pc[1:0] == 2'b00);

endmodule

//--- verilog/hazard_if.sv
interface hazard_if import core_pkg::*; ();

	logic     stall_fetch;     // Hold PC
	logic     stall_decode;    // Hold IF/ID, bubble into ID/EXE
	logic     flush_decode;    // IF/ID becomes a no-op
	logic     flush_exe;       // ID/EXE becomes a bubble
	fwd_sel_t fwd_a;           // Source of rs1 in decode
	fwd_sel_t fwd_b;           // Source of rs2 in decode

	modport hazard (
		output stall_fetch, stall_decode, flush_decode, flush_exe, fwd_a, fwd_b
	);

	// IF/ID register enable lives in fetch
	modport fetch (
		input stall_fetch, stall_decode, flush_decode
	);

	modport decode (
		input fwd_a, fwd_b, flush_exe
	);

endinterface

//--- verilog/hazard_unit.sv
module hazard_unit import core_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t id_rs1,
	input  reg_addr_t id_rs2,
	input  id_exe_t   id_exe,
	input  exe_mem_t  exe_mem,
	input  rf_write_t wb,
	input  logic      redirect_taken,
	input  logic      jal_taken,
	hazard_if.hazard  hz
);

	logic load_use;

	// Youngest producer wins; x0 is a constant and never forwarded
	function automatic fwd_sel_t fwd_src(reg_addr_t rs);
		if (rs == '0)
			return fwd_none;
		else if (id_exe.wr_en && id_exe.rd == rs)
			return fwd_exe;
		else if (exe_mem.wr_en && exe_mem.rd == rs)
			return fwd_mem;
		else if (wb.en && wb.rd == rs)
			return fwd_wb;
		else
			return fwd_none;
	endfunction

	// Load data only exists in MEM, so a consumer right behind it waits once
	assign load_use = id_exe.is_load &&
		((id_rs1 != '0 && id_rs1 == id_exe.rd) ||
		 (id_rs2 != '0 && id_rs2 == id_exe.rd));

	assign hz.stall_fetch  = load_use;
	assign hz.stall_decode = load_use;
	assign hz.flush_decode = redirect_taken | jal_taken;   // Both kill the IF/ID entry
	assign hz.flush_exe    = redirect_taken;               // Branch also kills the ID entry

	assign hz.fwd_a        = fwd_src(id_rs1);
	assign hz.fwd_b        = fwd_src(id_rs2);

	// A load and a branch never share EXE, so stall and redirect stay apart
	a_stall_no_redirect: assert property (@(posedge clk) disable iff (!rst_n)
		hz.stall_fetch |-> !hz.flush_exe);

endmodule

//--- verilog/memory_stage.sv
module memory_stage import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  exe_mem_t   exe_mem,
	input  logic       con_write,
	input  dmem_addr_t con_addr,
	input  xlen_t      con_in,
	output xlen_t      con_out,
	output xlen_t      mem_fwd_data,
	output rf_write_t  wb
);

	xlen_t      dmem [dmem_words];
	dmem_addr_t core_addr;
	xlen_t      load_data;
	mem_wb_t    mem_wb;

	assign core_addr = dmem_addr_t'(exe_mem.alu_result >> 2);   // Word index
	assign load_data = dmem[core_addr];                       // Async core read

	always_ff @(posedge clk) begin
		if (exe_mem.is_store)
			dmem[core_addr] <= exe_mem.store_data;
		if (con_write)
			dmem[con_addr] <= con_in;   // Last assignment, wins on a shared word
		con_out <= dmem[con_addr];      // Controller sees it one cycle later
	end

	assign mem_fwd_data = wb_mux(exe_mem.wb_sel, exe_mem.alu_result, load_data, exe_mem.pc4);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb.wr_en <= 1'b0;
		end else begin
			mem_wb <= '{
				alu_result: exe_mem.alu_result,
				load_data:  load_data,
				pc4:        exe_mem.pc4,
				rd:         exe_mem.rd,
				wr_en:      exe_mem.wr_en,
				wb_sel:     exe_mem.wb_sel
			};
		end
	end

	// Writeback word, also the WB forward into decode
	assign wb = '{
		en:   mem_wb.wr_en,
		rd:   mem_wb.rd,
		data: wb_mux(mem_wb.wb_sel, mem_wb.alu_result, mem_wb.load_data, mem_wb.pc4)
	};

endmodule
